// File: files.f
source/pnp_bus_pkg.sv
source/pnp_cfg_pkg.sv
source/pnp_wb_decode.sv
source/pnp_reg_bank.sv
source/pnp_read_mux.sv
source/pnp_config_top.sv
test/pnp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module pnp_tb -f files.f \
  --Mdir obj_dir -o pnp_sim || { echo "build failed"; exit 1; }
./obj_dir/pnp_sim > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "result: fail"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "result: no pass line in log"; exit 1; }
echo "result: pass"

// File: source/pnp_bus_pkg.sv
// Wishbone classic signal bundles and the decoded request passed between the config slave blocks
package pnp_bus_pkg;

  localparam int WB_ADR_W = 10;  // word address, 1024 words
  localparam int WB_DAT_W = 32;
  localparam int WB_SEL_W = WB_DAT_W / 8;

  // master to slave
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
    logic [WB_SEL_W-1:0] sel;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  // request as seen by the register bank and read mux
  typedef struct packed {
    logic                valid;    // one accepted transfer this cycle
    logic                we;
    logic [WB_ADR_W-1:0] idx;      // word index
    logic [WB_DAT_W-1:0] wdata;
    logic                any_sel;  // at least one byte lane enabled
  } pnp_req_t;

endpackage

// File: source/pnp_cfg_pkg.sv
// Plug-and-play content definitions: descriptors, identity constants and the register word map
package pnp_cfg_pkg;

  // one device descriptor as delivered by the interconnect
  typedef struct packed {
    logic [1:0]  descrtype;
    logic [7:0]  descrsize;
    logic [15:0] vid;
    logic [15:0] did;
    logic [19:0] xaddr;  // zero for masters
    logic [19:0] xmask;  // zero for masters
  } pnp_descr_t;

  localparam int CFG_MST_TOTAL = 2;
  localparam int CFG_SLV_TOTAL = 3;

  typedef pnp_descr_t [CFG_MST_TOTAL-1:0] pnp_mst_vec_t;
  typedef pnp_descr_t [CFG_SLV_TOTAL-1:0] pnp_slv_vec_t;

  // identity and capability fields
  localparam logic [31:0] HW_ID        = 32'h20170101;
  localparam logic [3:0]  CPU_MAX      = 4'd1;
  localparam logic        L2CACHE_ENA  = 1'b1;
  localparam logic [7:0]  PLIC_IRQ_MAX = 8'd127;

  // number of 64-bit firmware scratch values
  localparam int SCRATCH_TOTAL = 6;

  // words per table entry
  localparam int MST_WORDS = 2 * CFG_MST_TOTAL;
  localparam int SLV_WORDS = 4 * CFG_SLV_TOTAL;

  // word map
  localparam int IDX_HW_ID        = 0;  // write raises self-test irq
  localparam int IDX_FW_ID        = 1;
  localparam int IDX_CAPS         = 2;
  localparam int IDX_SCRATCH_BASE = 4;  // low half even, high half odd
  localparam int IDX_MST_BASE     = IDX_SCRATCH_BASE + 2 * SCRATCH_TOTAL;
  localparam int IDX_SLV_BASE     = IDX_MST_BASE + MST_WORDS;
  localparam int IDX_END          = IDX_SLV_BASE + SLV_WORDS;

  // firmware writable state
  typedef struct packed {
    logic [31:0] fw_id;
    logic [63:0] idt;          // debug counter
    logic [63:0] malloc_addr;  // allocation base
    logic [63:0] malloc_size;
    logic [63:0] fwdbg1;       // fw debug markers
    logic [63:0] fwdbg2;
    logic [63:0] fwdbg3;
  } pnp_regs_t;

endpackage

// File: source/pnp_config_top.sv
// Plug-and-play configuration slave top: Wishbone port, descriptor tables in, self-test irq out
`timescale 1ns/1ns

module pnp_config_top (
  input  logic                      sys_clk,
  input  logic                      nrst,
  input  pnp_bus_pkg::wb_req_t      i_wb,
  output pnp_bus_pkg::wb_rsp_t      o_wb,
  input  pnp_cfg_pkg::pnp_mst_vec_t i_mstcfg,
  input  pnp_cfg_pkg::pnp_slv_vec_t i_slvcfg,
  output logic                      o_irq
);

  pnp_bus_pkg::pnp_req_t  w_req;
  pnp_cfg_pkg::pnp_regs_t w_regs;
  logic        w_ack;
  logic [31:0] w_rdata;

  pnp_wb_decode i_pnp_wb_decode (
    .sys_clk (sys_clk),
    .nrst    (nrst),
    .i_wb    (i_wb),
    .o_req   (w_req),
    .o_ack   (w_ack)
  );

  pnp_reg_bank i_pnp_reg_bank (
    .sys_clk (sys_clk),
    .nrst    (nrst),
    .i_req   (w_req),
    .o_regs  (w_regs),
    .o_irq   (o_irq)
  );

  pnp_read_mux i_pnp_read_mux (
    .sys_clk  (sys_clk),
    .nrst     (nrst),
    .i_req    (w_req),
    .i_regs   (w_regs),
    .i_mstcfg (i_mstcfg),
    .i_slvcfg (i_slvcfg),
    .o_rdata  (w_rdata)
  );

  assign o_wb = '{ack: w_ack, dat: w_rdata};

endmodule

// File: source/pnp_read_mux.sv
// Read path of the config slave: selects the addressed word from constants, registers and tables
`timescale 1ns/1ns

module pnp_read_mux (
  input  logic                      sys_clk,
  input  logic                      nrst,
  input  pnp_bus_pkg::pnp_req_t     i_req,
  input  pnp_cfg_pkg::pnp_regs_t    i_regs,
  input  pnp_cfg_pkg::pnp_mst_vec_t i_mstcfg,
  input  pnp_cfg_pkg::pnp_slv_vec_t i_slvcfg,
  output logic [31:0]               o_rdata
);

  logic [2*pnp_cfg_pkg::SCRATCH_TOTAL-1:0][31:0] w_halves;
  logic [pnp_cfg_pkg::MST_WORDS-1:0][31:0] w_mst_words;
  logic [pnp_cfg_pkg::SLV_WORDS-1:0][31:0] w_slv_words;
  logic [31:0] w_caps;
  logic [31:0] w_word;

  logic [9:0] w_half_off;
  logic [9:0] w_mst_off;
  logic [9:0] w_slv_off;
  logic [$clog2(2*pnp_cfg_pkg::SCRATCH_TOTAL)-1:0] w_half_sel;
  logic [$clog2(pnp_cfg_pkg::MST_WORDS)-1:0] w_mst_sel;
  logic [$clog2(pnp_cfg_pkg::SLV_WORDS)-1:0] w_slv_sel;

  assign w_caps = {pnp_cfg_pkg::CPU_MAX, 3'b000, pnp_cfg_pkg::L2CACHE_ENA,
                   8'(pnp_cfg_pkg::CFG_MST_TOTAL), 8'(pnp_cfg_pkg::CFG_SLV_TOTAL),
                   pnp_cfg_pkg::PLIC_IRQ_MAX};

  // entry 0 is the low half of idt
  assign w_halves = {i_regs.fwdbg3, i_regs.fwdbg2, i_regs.fwdbg1,
                     i_regs.malloc_size, i_regs.malloc_addr, i_regs.idt};

  for (genvar k = 0; k < pnp_cfg_pkg::CFG_MST_TOTAL; k++) begin : g_mst
    assign w_mst_words[2*k]   = {22'h0, i_mstcfg[k].descrtype, i_mstcfg[k].descrsize};
    assign w_mst_words[2*k+1] = {i_mstcfg[k].vid, i_mstcfg[k].did};
  end

  for (genvar k = 0; k < pnp_cfg_pkg::CFG_SLV_TOTAL; k++) begin : g_slv
    assign w_slv_words[4*k]   = {22'h0, i_slvcfg[k].descrtype, i_slvcfg[k].descrsize};
    assign w_slv_words[4*k+1] = {i_slvcfg[k].vid, i_slvcfg[k].did};
    assign w_slv_words[4*k+2] = {i_slvcfg[k].xmask, 12'h000};
    assign w_slv_words[4*k+3] = {i_slvcfg[k].xaddr, 12'h000};
  end

  // offsets into each region
  assign w_half_off = i_req.idx - 10'(pnp_cfg_pkg::IDX_SCRATCH_BASE);
  assign w_mst_off  = i_req.idx - 10'(pnp_cfg_pkg::IDX_MST_BASE);
  assign w_slv_off  = i_req.idx - 10'(pnp_cfg_pkg::IDX_SLV_BASE);
  assign w_half_sel = w_half_off[$bits(w_half_sel)-1:0];
  assign w_mst_sel  = w_mst_off[$bits(w_mst_sel)-1:0];
  assign w_slv_sel  = w_slv_off[$bits(w_slv_sel)-1:0];

  always_comb begin
    w_word = '0;  // reserved and unmapped words
    if (i_req.idx == 10'(pnp_cfg_pkg::IDX_HW_ID)) begin
      w_word = pnp_cfg_pkg::HW_ID;
    end else if (i_req.idx == 10'(pnp_cfg_pkg::IDX_FW_ID)) begin
      w_word = i_regs.fw_id;
    end else if (i_req.idx == 10'(pnp_cfg_pkg::IDX_CAPS)) begin
      w_word = w_caps;
    end else if (i_req.idx >= 10'(pnp_cfg_pkg::IDX_SCRATCH_BASE) &&
                 i_req.idx < 10'(pnp_cfg_pkg::IDX_MST_BASE)) begin
      w_word = w_halves[w_half_sel];
    end else if (i_req.idx >= 10'(pnp_cfg_pkg::IDX_MST_BASE) &&
                 i_req.idx < 10'(pnp_cfg_pkg::IDX_SLV_BASE)) begin
      w_word = w_mst_words[w_mst_sel];
    end else if (i_req.idx >= 10'(pnp_cfg_pkg::IDX_SLV_BASE) &&
                 i_req.idx < 10'(pnp_cfg_pkg::IDX_END)) begin
      w_word = w_slv_words[w_slv_sel];
    end
  end

  always_ff @(posedge sys_clk or negedge nrst) begin
    if (!nrst) begin
      o_rdata <= '0;
    end else if (i_req.valid & ~i_req.we) begin
      o_rdata <= w_word;  // lines up with ack
    end
  end

endmodule

// File: source/pnp_reg_bank.sv
// Firmware writable registers of the config slave and the self-test interrupt pulse
`timescale 1ns/1ns

module pnp_reg_bank (
  input  logic                   sys_clk,
  input  logic                   nrst,
  input  pnp_bus_pkg::pnp_req_t  i_req,
  output pnp_cfg_pkg::pnp_regs_t o_regs,
  output logic                   o_irq
);

  logic [31:0] r_fw_id;
  logic [pnp_cfg_pkg::SCRATCH_TOTAL-1:0][63:0] r_scratch;
  logic r_irq;

  logic       w_wr;
  logic       w_in_scratch;
  logic       w_hit_id;
  logic       w_hit_fw;
  logic [3:0] w_offs;
  logic [2:0] w_slot;

  assign w_wr = i_req.valid & i_req.we & i_req.any_sel;

  assign w_hit_id = (i_req.idx == 10'(pnp_cfg_pkg::IDX_HW_ID));
  assign w_hit_fw = (i_req.idx == 10'(pnp_cfg_pkg::IDX_FW_ID));
  assign w_in_scratch = (i_req.idx >= 10'(pnp_cfg_pkg::IDX_SCRATCH_BASE)) &&
                        (i_req.idx < 10'(pnp_cfg_pkg::IDX_MST_BASE));

  // word offset inside the scratch area
  assign w_offs = 4'(i_req.idx - 10'(pnp_cfg_pkg::IDX_SCRATCH_BASE));
  assign w_slot = w_offs[3:1];  // which 64-bit value

  always_ff @(posedge sys_clk or negedge nrst) begin
    if (!nrst) begin
      r_fw_id   <= '0;
      r_scratch <= '0;
    end else if (w_wr) begin
      if (w_hit_fw) begin
        r_fw_id <= i_req.wdata;
      end else if (w_in_scratch) begin
        if (w_offs[0]) begin
          r_scratch[w_slot][63:32] <= i_req.wdata;  // odd word
        end else begin
          r_scratch[w_slot][31:0] <= i_req.wdata;
        end
      end
    end
  end

  // id word is read only, a write requests the self-test
  always_ff @(posedge sys_clk or negedge nrst) begin
    if (!nrst) begin
      r_irq <= 1'b0;
    end else begin
      r_irq <= w_wr & w_hit_id;
    end
  end

  assign o_irq = r_irq;

  assign o_regs = '{
    fw_id:       r_fw_id,
    idt:         r_scratch[0],
    malloc_addr: r_scratch[1],
    malloc_size: r_scratch[2],
    fwdbg1:      r_scratch[3],
    fwdbg2:      r_scratch[4],
    fwdbg3:      r_scratch[5]
  };

endmodule

// File: source/pnp_wb_decode.sv
// Wishbone classic front end of the config slave: accepts a cycle, builds the decoded request, acks
`timescale 1ns/1ns

module pnp_wb_decode (
  input  logic                 sys_clk,
  input  logic                 nrst,
  input  pnp_bus_pkg::wb_req_t i_wb,
  output pnp_bus_pkg::pnp_req_t o_req,
  output logic                 o_ack
);

  logic w_valid;
  logic w_any_sel;
  logic r_ack;

  // accept only while no ack is out, so ack is a single-cycle pulse
  assign w_valid   = i_wb.cyc & i_wb.stb & ~r_ack;
  assign w_any_sel = |i_wb.sel;

  assign o_req = '{
    valid:   w_valid,
    we:      i_wb.we,
    idx:     i_wb.adr,
    wdata:   i_wb.dat,
    any_sel: w_any_sel
  };

  always_ff @(posedge sys_clk or negedge nrst) begin
    if (!nrst) begin
      r_ack <= 1'b0;
    end else begin
      r_ack <= w_valid;  // answer one cycle after accept
    end
  end

  assign o_ack = r_ack;

endmodule

// File: test/pnp_tb.sv
// Directed testbench for the plug-and-play config slave that runs with pnp_tb as top module
`timescale 1ns/1ns

module pnp_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int ACK_LIMIT      = 4;     // cycles allowed until ack
  localparam int TRANSFER_COUNT = 1100;  // bus transfers over all tests rounded up
  localparam int WATCHDOG_NS    = (TRANSFER_COUNT * ACK_LIMIT + 20) * CLK_PERIOD;

  localparam int MST_IW = $clog2(pnp_cfg_pkg::CFG_MST_TOTAL);
  localparam int SLV_IW = $clog2(pnp_cfg_pkg::CFG_SLV_TOTAL);

  // firmware view of the word map
  localparam int MST_BASE = 16;
  localparam int SLV_BASE = 20;
  localparam int MAP_END  = 32;
  localparam logic [31:0] EXP_HW_ID = 32'h20170101;
  localparam logic [31:0] EXP_CAPS  = 32'h1102037F;  // cpu 1, l2 on, 2 mst, 3 slv, 127 irqs

  logic                      sys_clk;
  logic                      nrst;
  pnp_bus_pkg::wb_req_t      wb_req;
  pnp_bus_pkg::wb_rsp_t      wb_rsp;
  pnp_cfg_pkg::pnp_mst_vec_t mstcfg;
  pnp_cfg_pkg::pnp_slv_vec_t slvcfg;
  logic                      irq;

  logic [31:0] rng_state;
  logic [31:0] model_fw_id;
  logic [31:0] model_halves [0:11];  // low half of each value at even entries
  int          last_latency;         // negedges from drive to ack

  pnp_config_top i_pnp_config_top (
    .sys_clk  (sys_clk),
    .nrst     (nrst),
    .i_wb     (wb_req),
    .o_wb     (wb_rsp),
    .i_mstcfg (mstcfg),
    .i_slvcfg (slvcfg),
    .o_irq    (irq)
  );

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog");
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "first mismatch");
    end
  endtask

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  function automatic pnp_cfg_pkg::pnp_descr_t random_descr(input bit is_slave);
    pnp_cfg_pkg::pnp_descr_t d;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = next_rand();
    b = next_rand();
    c = next_rand();
    d.descrtype = a[1:0];
    d.descrsize = a[9:2];
    d.vid       = b[31:16];
    d.did       = b[15:0];
    d.xaddr     = is_slave ? c[19:0] : 20'h0;  // masters carry no window
    d.xmask     = is_slave ? {c[31:20], a[31:24]} : 20'h0;
    return d;
  endfunction

  task automatic fill_descriptors();
    for (int k = 0; k < pnp_cfg_pkg::CFG_MST_TOTAL; k++) begin
      mstcfg[MST_IW'(k)] = random_descr(1'b0);
    end
    for (int k = 0; k < pnp_cfg_pkg::CFG_SLV_TOTAL; k++) begin
      slvcfg[SLV_IW'(k)] = random_descr(1'b1);
    end
  endtask

  task automatic model_write(input int idx, input logic [31:0] data, input logic [3:0] sel);
    if (sel != 4'h0) begin
      if (idx == 1) begin
        model_fw_id = data;
      end else if (idx >= 4 && idx < MST_BASE) begin
        model_halves[idx - 4] = data;
      end
    end
  endtask

  // reference model of the read map
  function automatic logic [31:0] expected_word(input int idx);
    logic [MST_IW-1:0] km;
    logic [SLV_IW-1:0] ks;
    logic [31:0]       w;
    w = 32'h0;
    if (idx == 0) begin
      w = EXP_HW_ID;
    end else if (idx == 1) begin
      w = model_fw_id;
    end else if (idx == 2) begin
      w = EXP_CAPS;
    end else if (idx >= 4 && idx < MST_BASE) begin
      w = model_halves[idx - 4];
    end else if (idx >= MST_BASE && idx < SLV_BASE) begin
      km = MST_IW'((idx - MST_BASE) / 2);
      if ((idx - MST_BASE) % 2 == 0) begin
        w = {22'h0, mstcfg[km].descrtype, mstcfg[km].descrsize};
      end else begin
        w = {mstcfg[km].vid, mstcfg[km].did};
      end
    end else if (idx >= SLV_BASE && idx < MAP_END) begin
      ks = SLV_IW'((idx - SLV_BASE) / 4);
      case ((idx - SLV_BASE) % 4)
        0:       w = {22'h0, slvcfg[ks].descrtype, slvcfg[ks].descrsize};
        1:       w = {slvcfg[ks].vid, slvcfg[ks].did};
        2:       w = {slvcfg[ks].xmask, 12'h000};
        default: w = {slvcfg[ks].xaddr, 12'h000};
      endcase
    end
    return w;
  endfunction

  // starts and ends on a falling edge and hold keeps stb up for the next transfer
  task automatic bus_transfer(input logic we, input int idx, input logic [31:0] wdata,
                              input logic [3:0] sel, input bit hold,
                              output logic [31:0] rdata);
    int   cycles;
    logic got_ack;
    logic irq_exp;
    cycles  = 0;
    got_ack = 1'b0;
    irq_exp = we && (idx == 0) && (sel != 4'h0);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = 10'(idx);
    wb_req.dat = wdata;
    wb_req.sel = sel;
    while (!got_ack) begin
      @(negedge sys_clk);
      cycles++;
      if (wb_rsp.ack) begin
        got_ack = 1'b1;
      end else begin
        check_equal(32'(irq), 32'h0, "irq outside an ack cycle");
        if (cycles >= ACK_LIMIT) begin
          stop_run($sformatf("no acknowledge within %0d cycles for word %0d", ACK_LIMIT, idx));
        end
      end
    end
    rdata        = wb_rsp.dat;
    last_latency = cycles;
    check_equal(32'(irq), 32'(irq_exp), $sformatf("irq in ack cycle of word %0d", idx));
    if (!hold) begin
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
      @(negedge sys_clk);
      check_equal(32'(wb_rsp.ack), 32'h0, "ack longer than one cycle");
      check_equal(32'(irq), 32'h0, "irq longer than one cycle");
    end
  endtask

  task automatic wb_write(input int idx, input logic [31:0] data, input logic [3:0] sel,
                          input bit hold);
    logic [31:0] unused_rdata;
    bus_transfer(1'b1, idx, data, sel, hold, unused_rdata);
    model_write(idx, data, sel);
  endtask

  task automatic wb_read(input int idx, input bit hold, output logic [31:0] data);
    bus_transfer(1'b0, idx, 32'h0, 4'hF, hold, data);
  endtask

  task automatic read_check(input int idx, input bit hold);
    logic [31:0] data;
    wb_read(idx, hold, data);
    check_equal(data, expected_word(idx), $sformatf("read of word %0d", idx));
  endtask

  task automatic reset_state_reads();
    check_equal(32'(irq), 32'h0, "irq after reset");
    check_equal(32'(wb_rsp.ack), 32'h0, "ack after reset");
    for (int idx = 0; idx < MST_BASE; idx++) begin
      read_check(idx, 1'b0);
    end
  endtask

  task automatic scratch_write_readback();
    logic [31:0] r;
    logic [3:0]  sel;
    int          n;
    int          idx;
    for (int i = 0; i < 28; i++) begin
      r   = next_rand();
      n   = (i < 13) ? i : int'(r % 32'd13);  // every word once, then random
      idx = (n == 0) ? 1 : n + 3;  // word 1 or 4..15
      sel = (r[7:4] == 4'h0) ? 4'hF : r[7:4];
      if (i >= 20) begin
        sel = 4'h0;  // no lane enabled so nothing is stored
      end
      wb_write(idx, next_rand(), sel, 1'b0);
      read_check(idx, 1'b0);
    end
  endtask

  task automatic id_word_self_test();
    wb_write(0, next_rand(), 4'hF, 1'b0);
    read_check(0, 1'b0);
    wb_write(0, next_rand(), 4'h0, 1'b0);
  endtask

  task automatic descriptor_table_reads();
    for (int idx = MST_BASE; idx < MAP_END; idx++) begin
      read_check(idx, 1'b0);
    end
    read_check(3, 1'b0);
    for (int idx = MAP_END; idx < 1024; idx++) begin
      read_check(idx, 1'b0);
    end
  endtask

  task automatic back_to_back_transfers();
    logic [31:0] r;
    int          idx;
    for (int n = 0; n < 6; n++) begin
      r   = next_rand();
      idx = 4 + int'(r % 32'd12);
      wb_write(idx, next_rand(), 4'hF, 1'b1);
      if (n > 0) begin
        check_equal(32'(last_latency), 32'd2, "turn-around with stb held");
      end
      read_check(idx, (n == 5) ? 1'b0 : 1'b1);
      check_equal(32'(last_latency), 32'd2, "read right after write");
    end
  endtask

  initial begin
    last_latency = 0;
    rng_state    = 32'd30;
    nrst         = 1'b0;
    wb_req       = '0;
    mstcfg       = '0;
    slvcfg       = '0;
    model_fw_id  = '0;
    for (int i = 0; i < 12; i++) begin
      model_halves[i] = '0;
    end
    fill_descriptors();
    repeat (2) @(negedge sys_clk);
    nrst = 1'b1;  // released on a falling edge
    reset_state_reads();
    scratch_write_readback();
    id_word_self_test();
    descriptor_table_reads();
    back_to_back_transfers();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
